// ==== common/cam_cfg_pkg.sv ====
package cam_cfg_pkg;

    //////////////////////////////
    // Register table geometry
    //////////////////////////////

    localparam int CFG_DEPTH = 16;
    localparam int CFG_IDX_W = 4;

    // Upper byte is the register address, lower byte the value
    typedef logic [15:0] cfg_entry_t;

    localparam cfg_entry_t CFG_END = 16'hffff;

    // 7-bit address 0x21 with the write bit cleared
    localparam logic [7:0] CAM_DEV_ADDR = 8'h42;

    //////////////////////////////
    // Camera register writes
    //////////////////////////////

    localparam cfg_entry_t CFG_TABLE [CFG_DEPTH] = '{
        16'h1280,   // COM7 soft reset
        16'h1204,   // COM7 RGB output
        16'h1101,   // CLKRC prescaler
        16'h0c04,   // COM3 scaling enable
        16'h3e19,   // COM14 pclk divider
        16'h4010,   // COM15 RGB565
        16'h8c00,   // RGB444 off
        16'h0400,
        16'h1438,   // COM9 gain ceiling
        16'h4fb3,
        16'h50b3,
        16'h5100,
        CFG_END,
        CFG_END,
        CFG_END,
        CFG_END
    };

endpackage

// ==== common/sccb_pkg.sv ====
package sccb_pkg;

    //////////////////////////////
    // Frame layout
    //////////////////////////////

    // Sent MSB first, device address leads
    typedef struct packed {
        logic [7:0] dev_addr;
        logic [7:0] reg_addr;
        logic [7:0] value;
    } sccb_frame_t;

    //////////////////////////////
    // Bus timing in ticks
    //////////////////////////////

    // SCL low, high, high, low for each bit
    localparam int TICKS_PER_BIT = 4;

    // SDA low ahead of the first SCL fall
    localparam int START_TICKS = 3;

    // SCL high ahead of the SDA rise
    localparam int STOP_TICKS = 2;

    // Phase counter, wide enough for every step above
    localparam int PHASE_W = $clog2(TICKS_PER_BIT) + 1;

    //////////////////////////////
    // Status
    //////////////////////////////

    localparam int COUNT_W = 5;

endpackage

// ==== common/sccb_frame_if.sv ====
`timescale 1ns/1ps

interface sccb_frame_if;

    import sccb_pkg::*;

    logic        frame_valid;
    sccb_frame_t frame;
    logic        busy;
    logic        frame_done;
    logic        ack_missing;
    logic        halt;

    modport seq (
        output frame_valid,
        output frame,
        input  busy,
        input  halt
    );

    modport eng (
        input  frame_valid,
        input  frame,
        output busy,
        output frame_done,
        output ack_missing
    );

    modport stat (
        input  frame_done,
        input  ack_missing,
        output halt
    );

endinterface

// ==== source/cfg_sequencer.sv ====
`timescale 1ns/1ps

module cfg_sequencer (
    input  logic         clk,
    input  logic         reset,
    sccb_frame_if.seq    bus,
    output logic         table_end
);

    import cam_cfg_pkg::*;

    typedef enum logic [2:0] {
        SQ_READ,
        SQ_ISSUE,
        SQ_SENT,
        SQ_BUSY,
        SQ_IDLE
    } seq_state_e;

    seq_state_e           state;
    logic [CFG_IDX_W-1:0] idx;
    logic [CFG_IDX_W-1:0] rd_idx;
    logic                 rd_en;
    cfg_entry_t           entry_q;

    //////////////////////////////
    // Table read
    //////////////////////////////

    // First read at index 0, later ones fetch the next slot
    assign rd_en  = (state == SQ_READ) || (state == SQ_BUSY && !bus.busy);
    assign rd_idx = (state == SQ_READ) ? idx : idx + 1'b1;

    always_ff @(posedge clk) begin
        if (rd_en) begin
            entry_q <= CFG_TABLE[rd_idx];
        end
    end

    //////////////////////////////
    // Frame issue
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (state == SQ_ISSUE) begin
            bus.frame <= {CAM_DEV_ADDR, entry_q};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state           <= SQ_READ;
            idx             <= '0;
            bus.frame_valid <= 1'b0;
            table_end       <= 1'b0;
        end else begin
            bus.frame_valid <= 1'b0;
            table_end       <= 1'b0;
            case (state)
                SQ_READ: begin
                    state <= SQ_ISSUE;
                end
                SQ_ISSUE: begin
                    if (bus.halt) begin
                        state <= SQ_IDLE;
                    end else if (entry_q == CFG_END) begin
                        table_end <= 1'b1;
                        state     <= SQ_IDLE;
                    end else if (!bus.busy) begin
                        bus.frame_valid <= 1'b1;
                        state           <= SQ_SENT;
                    end
                end
                SQ_SENT: begin
                    // Engine latches here, busy follows next cycle
                    state <= SQ_BUSY;
                end
                SQ_BUSY: begin
                    if (!bus.busy) begin
                        idx   <= rd_idx;
                        state <= SQ_ISSUE;
                    end
                end
                default: begin
                    state <= SQ_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== sccb/sccb_write_engine.sv ====
`timescale 1ns/1ps

module sccb_write_engine #(
    parameter int CLKS_PER_TICK = 25000
) (
    input  logic         clk,
    input  logic         reset,
    sccb_frame_if.eng    bus,
    output logic         scl,
    inout  logic         sda
);

    import sccb_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_BIT,
        ST_STOP
    } eng_state_e;

    localparam int MSB = $bits(sccb_frame_t) - 1;

    logic [$clog2(CLKS_PER_TICK)-1:0] div_cnt;
    logic                             tick;

    eng_state_e         state;
    logic [PHASE_W-1:0] phase;
    logic [3:0]         bit_idx;
    logic [1:0]         byte_idx;
    logic               ack_slot;
    logic               last_phase;
    logic               shift_en;
    logic               sda_low;
    logic [1:0]         sda_sync;
    sccb_frame_t        shift_q;

    //////////////////////////////
    // Tick divider
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_cnt == $bits(div_cnt)'(CLKS_PER_TICK - 1)) begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

    // Open drain, pulled up off chip
    assign sda = sda_low ? 1'b0 : 1'bz;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sda_sync <= 2'b11;
        end else begin
            sda_sync <= {sda_sync[0], sda};
        end
    end

    // Ninth slot of each byte is the acknowledge
    assign ack_slot   = (bit_idx == 4'd8);
    assign last_phase = (phase == PHASE_W'(TICKS_PER_BIT - 1));
    assign shift_en   = tick && (state == ST_BIT) && last_phase && !ack_slot;

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && bus.frame_valid) begin
            shift_q <= bus.frame;
        end else if (shift_en) begin
            shift_q <= {shift_q[MSB-1:0], 1'b0};
        end
    end

    //////////////////////////////
    // Bus state machine
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state           <= ST_IDLE;
            phase           <= '0;
            bit_idx         <= '0;
            byte_idx        <= '0;
            scl             <= 1'b1;
            sda_low         <= 1'b0;
            bus.busy        <= 1'b0;
            bus.frame_done  <= 1'b0;
            bus.ack_missing <= 1'b0;
        end else begin
            bus.frame_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (bus.frame_valid) begin
                        state           <= ST_START;
                        phase           <= '0;
                        bit_idx         <= '0;
                        byte_idx        <= '0;
                        bus.busy        <= 1'b1;
                        bus.ack_missing <= 1'b0;
                    end
                end
                ST_START: begin
                    if (tick) begin
                        // SDA falls with SCL high
                        sda_low <= 1'b1;
                        if (phase == PHASE_W'(START_TICKS)) begin
                            scl   <= 1'b0;
                            phase <= '0;
                            state <= ST_BIT;
                        end else begin
                            phase <= phase + 1'b1;
                        end
                    end
                end
                ST_BIT: begin
                    if (tick) begin
                        phase <= phase + 1'b1;
                        if (phase == '0) begin
                            scl     <= 1'b0;
                            sda_low <= ack_slot ? 1'b0 : !shift_q[MSB];
                        end else if (phase == PHASE_W'(1)) begin
                            scl <= 1'b1;
                        end else if (phase == PHASE_W'(TICKS_PER_BIT / 2)) begin
                            // Mid SCL high, released SDA reads as NACK
                            if (ack_slot && sda_sync[1]) begin
                                bus.ack_missing <= 1'b1;
                            end
                        end
                        if (last_phase) begin
                            scl   <= 1'b0;
                            phase <= '0;
                            if (!ack_slot) begin
                                bit_idx <= bit_idx + 1'b1;
                            end else if (byte_idx == 2'd2) begin
                                bit_idx <= '0;
                                state   <= ST_STOP;
                            end else begin
                                bit_idx  <= '0;
                                byte_idx <= byte_idx + 1'b1;
                            end
                        end
                    end
                end
                ST_STOP: begin
                    if (tick) begin
                        phase <= phase + 1'b1;
                        if (phase == '0) begin
                            sda_low <= 1'b1;
                        end else if (phase == PHASE_W'(1)) begin
                            scl <= 1'b1;
                        end else if (phase == PHASE_W'(STOP_TICKS + 1)) begin
                            sda_low        <= 1'b0;
                            phase          <= '0;
                            state          <= ST_IDLE;
                            bus.busy       <= 1'b0;
                            bus.frame_done <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== source/cfg_status.sv ====
`timescale 1ns/1ps

module cfg_status (
    input  logic                        clk,
    input  logic                        reset,
    sccb_frame_if.stat                  bus,
    input  logic                        table_end,
    output logic                        done,
    output logic                        error,
    output logic [sccb_pkg::COUNT_W-1:0] write_count
);

    //////////////////////////////
    // Write count and run end
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done        <= 1'b0;
            error       <= 1'b0;
            bus.halt    <= 1'b0;
            write_count <= '0;
        end else if (!done) begin
            if (bus.frame_done) begin
                if (bus.ack_missing) begin
                    // Stop the sequencer, frame is not counted
                    error    <= 1'b1;
                    bus.halt <= 1'b1;
                    done     <= 1'b1;
                end else begin
                    write_count <= write_count + 1'b1;
                end
            end
            if (table_end) begin
                done <= 1'b1;
            end
        end
    end

endmodule

// ==== source/cam_cfg_top.sv ====
`timescale 1ns/1ps

module cam_cfg_top #(
    parameter int CLKS_PER_TICK = 25000
) (
    input  logic                         clk,
    input  logic                         reset,
    output logic                         scl,
    inout  logic                         sda,
    output logic                         done,
    output logic                         error,
    output logic [sccb_pkg::COUNT_W-1:0] write_count
);

    logic table_end;

    sccb_frame_if frame_bus ();

    // Table entries to frames
    cfg_sequencer u_sequencer (
        .clk      (clk),
        .reset    (reset),
        .bus      (frame_bus.seq),
        .table_end(table_end)
    );

    sccb_write_engine #(
        .CLKS_PER_TICK(CLKS_PER_TICK)
    ) u_engine (
        .clk  (clk),
        .reset(reset),
        .bus  (frame_bus.eng),
        .scl  (scl),
        .sda  (sda)
    );

    cfg_status u_status (
        .clk        (clk),
        .reset      (reset),
        .bus        (frame_bus.stat),
        .table_end  (table_end),
        .done       (done),
        .error      (error),
        .write_count(write_count)
    );

endmodule

// ==== testbench/sccb_slave_model.sv ====
`timescale 1ns/1ps

module sccb_slave_model (
    input  logic                  reset,
    input  logic                  scl,
    inout  wire                   sda,
    input  int                    nack_frame,
    output int                    frame_count,
    output sccb_pkg::sccb_frame_t frame_data,
    output logic                  violation
);

    import sccb_pkg::*;

    // Three bytes with their acknowledge slots
    localparam int FRAME_BITS = 27;

    logic        in_frame;
    logic        ack_low;
    logic        prev_scl;
    logic        prev_sda;
    int          bit_cnt;
    sccb_frame_t shift_q;

    assign sda = ack_low ? 1'b0 : 1'bz;

    //////////////////////////////
    // Bus decoder
    //////////////////////////////

    always @(scl or sda or reset) begin
        if (reset) begin
            in_frame    = 1'b0;
            ack_low     = 1'b0;
            bit_cnt     = 0;
            shift_q     = '0;
            frame_count = 0;
            frame_data  = '0;
            violation   = 1'b0;
            prev_scl    = scl;
            prev_sda    = sda;
        end else begin
            if (prev_scl === 1'b1 && scl === 1'b1 && prev_sda === 1'b1 && sda === 1'b0) begin
                // Start, a second one inside a frame is illegal here
                if (in_frame) begin
                    violation = 1'b1;
                end
                in_frame = 1'b1;
                bit_cnt  = 0;
                shift_q  = '0;
            end else if (prev_scl === 1'b1 && scl === 1'b1 && prev_sda === 1'b0 &&
                         sda === 1'b1) begin
                // Stop comes one SCL pulse after the last acknowledge
                if (!in_frame || bit_cnt != FRAME_BITS + 1) begin
                    violation = 1'b1;
                end else begin
                    frame_data = shift_q;
                    frame_count++;
                end
                in_frame = 1'b0;
                ack_low  = 1'b0;
            end else if (prev_scl === 1'b0 && scl === 1'b1) begin
                if (!in_frame) begin
                    violation = 1'b1;
                end else begin
                    if (bit_cnt < FRAME_BITS && bit_cnt % 9 != 8) begin
                        shift_q = {shift_q[$bits(sccb_frame_t)-2:0], sda};
                    end
                    bit_cnt++;
                end
            end else if (prev_scl === 1'b1 && scl === 1'b0 && in_frame) begin
                if (bit_cnt % 9 == 8) begin
                    // Chosen frame gets its second acknowledge released
                    ack_low = !(frame_count == nack_frame && bit_cnt / 9 == 1);
                end else begin
                    ack_low = 1'b0;
                end
            end
            prev_scl = scl;
            prev_sda = sda;
        end
    end

endmodule

// ==== testbench/cam_cfg_tb.sv ====
`timescale 1ns/1ps

module cam_cfg_tb;

    import cam_cfg_pkg::*;
    import sccb_pkg::*;

    localparam int TABLE_WRITES = 12;
    localparam int DONE_TIMEOUT = 20000;
    localparam int QUIET_CYCLES = 2000;

    logic               clk;
    logic               reset;
    logic               scl;
    wire                sda;
    logic               done;
    logic               error;
    logic [COUNT_W-1:0] write_count;

    int          nack_frame;
    int          max_frames;
    int          frames_checked;
    int          frame_count;
    int          nack_pick;
    sccb_frame_t frame_data;
    logic        violation;

    pullup (sda);

    cam_cfg_top #(.CLKS_PER_TICK(4)) dut (
        .clk        (clk),
        .reset      (reset),
        .scl        (scl),
        .sda        (sda),
        .done       (done),
        .error      (error),
        .write_count(write_count)
    );

    sccb_slave_model u_slave (
        .reset      (reset),
        .scl        (scl),
        .sda        (sda),
        .nack_frame (nack_frame),
        .frame_count(frame_count),
        .frame_data (frame_data),
        .violation  (violation)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: expected %0h, actual %0h", test_name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // Device address, then register and value of table entry n
    function automatic sccb_frame_t expected_frame(input int n);
        sccb_frame_t f;
        f.dev_addr = CAM_DEV_ADDR;
        f.reg_addr = CFG_TABLE[n][15:8];
        f.value    = CFG_TABLE[n][7:0];
        return f;
    endfunction

    task automatic apply_reset(input string test_name);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        check_value({test_name, " scl"}, 1, scl);
        check_value({test_name, " sda"}, 1, sda);
        check_value({test_name, " done"}, 0, done);
        check_value({test_name, " error"}, 0, error);
        check_value({test_name, " write_count"}, 0, write_count);
        reset = 1'b0;
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            fail_run("Timed out waiting for done");
        end
    endtask

    task automatic watch_quiet(input string test_name, input int expected_frames);
        for (int cycles = 0; cycles < QUIET_CYCLES; cycles++) begin
            @(negedge clk);
        end
        check_value({test_name, " frames on bus"}, expected_frames, frame_count);
    endtask

    //////////////////////////////
    // Bus and frame checker
    //////////////////////////////

    always @(negedge clk) begin
        if (reset !== 1'b0) begin
            frames_checked = 0;
        end else begin
            assert (!violation) else begin
                $display("SDA changed while SCL was high, or a frame lacked start or stop");
                $display("RESULT: FAIL");
                $fatal(1);
            end
            if (frame_count != frames_checked) begin
                assert (frames_checked < max_frames) else begin
                    $display("Frame %0d appeared after the run should have ended",
                             frames_checked);
                    $display("RESULT: FAIL");
                    $fatal(1);
                end
                check_value($sformatf("frame %0d contents", frames_checked),
                            expected_frame(frames_checked), frame_data);
                frames_checked++;
            end
        end
    end

    initial begin
        nack_pick  = $urandom(32'haac7) % TABLE_WRITES;
        nack_frame = -1;
        max_frames = TABLE_WRITES;
        apply_reset("full run reset");
        wait_for_done();
        check_value("full run error", 0, error);
        check_value("full run write_count", TABLE_WRITES, write_count);
        watch_quiet("full run", TABLE_WRITES);

        nack_frame = nack_pick;
        max_frames = nack_pick + 1;
        $display("Missing acknowledge in frame %0d", nack_pick);
        apply_reset("nack run reset");
        wait_for_done();
        check_value("nack run error", 1, error);
        check_value("nack run write_count", nack_pick, write_count);
        watch_quiet("nack run", nack_pick + 1);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
common/cam_cfg_pkg.sv
common/sccb_pkg.sv
common/sccb_frame_if.sv
source/cfg_sequencer.sv
sccb/sccb_write_engine.sv
source/cfg_status.sv
source/cam_cfg_top.sv
testbench/sccb_slave_model.sv
testbench/cam_cfg_tb.sv
